// File: verilog/ldpc_pkg.sv
// ldpc code package: code sizes, edge tables, controller and requester enums, LLR type
package ldpc_pkg;

    // regular (2,4) code, 12 bits and 6 checks
    localparam int n_bits = 12;
    localparam int n_checks = 6;
    localparam int n_edges = 24;
    localparam int row_w = 4;
    localparam int col_w = 2;

    // magnitude clip for all LLR arithmetic
    localparam int llr_max = 31;
    localparam int max_iter_w = 5;

    // ram map: lr at 0..11, lq at 12..23, r at 24..47
    typedef logic [5:0] addr_t;

    // positive value means bit 0
    typedef logic signed [5:0] llr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_data_i,
        st_cnu,
        st_vnu,
        st_data_o
    } dec_state_e;

    // listed in falling priority
    typedef enum logic [1:0] {
        req_io,
        req_vnu,
        req_cnu
    } req_e;

    // bit index per edge, edges 4c..4c+3 belong to check c
    // checks 0..2 take bit groups of four, checks 3..5 take every third bit
    localparam logic [3:0] edge_bit [n_edges] = '{
        4'd0, 4'd1, 4'd2, 4'd3,
        4'd4, 4'd5, 4'd6, 4'd7,
        4'd8, 4'd9, 4'd10, 4'd11,
        4'd0, 4'd3, 4'd6, 4'd9,
        4'd1, 4'd4, 4'd7, 4'd10,
        4'd2, 4'd5, 4'd8, 4'd11
    };

    // the two edges of each bit, check index is edge / 4
    localparam logic [4:0] bit_edges [n_bits][col_w] = '{
        '{5'd0, 5'd12}, '{5'd1, 5'd16}, '{5'd2, 5'd20},
        '{5'd3, 5'd13}, '{5'd4, 5'd17}, '{5'd5, 5'd21},
        '{5'd6, 5'd14}, '{5'd7, 5'd18}, '{5'd8, 5'd22},
        '{5'd9, 5'd15}, '{5'd10, 5'd19}, '{5'd11, 5'd23}
    };

endpackage

// File: verilog/llr_mem_if.sv
// llr ram request bundle of one requester, arbiter answers with grant and read data
interface llr_mem_if #(
    parameter int llr_w = 6
);
    import ldpc_pkg::*;

    logic req;
    logic wr;
    addr_t addr;
    logic signed [llr_w-1:0] wdata;
    // comb grant, registered read data
    logic gnt;
    logic signed [llr_w-1:0] rdata;

    modport requester (output req, wr, addr, wdata, input gnt, rdata);
    modport arbiter (input req, wr, addr, wdata, output gnt, rdata);

endinterface

// File: verilog/ldpc_ctrl.sv
// decoder sequencer with phase FSM, iteration count, early stop and status flags
module ldpc_ctrl (
    input  logic clk,
    input  logic reset_n,
    input  logic sync_in,
    input  logic [ldpc_pkg::max_iter_w-1:0] max_iter,
    input  logic cnu_done,
    input  logic vnu_done,
    input  logic parity_ok,
    input  logic out_done,
    output logic cnu_start,
    output logic vnu_start,
    output logic load_start,
    output logic out_start,
    output logic busy,
    output logic finish,
    output logic [ldpc_pkg::max_iter_w-1:0] num_iter,
    output logic decode_err
);
    import ldpc_pkg::*;

    dec_state_e state;
    dec_state_e next_state;
    logic sync_dly;
    logic sync_dly2;
    logic sync_end;
    logic iter_end;
    logic enter_cnu;

    // frame end seen two cycles late
    assign sync_end = sync_dly2 & ~sync_dly;
    assign iter_end = num_iter == max_iter;
    assign enter_cnu = (next_state == st_cnu) && (state != st_cnu);

    always_comb
    begin
        next_state = state;
        case (state)
            st_idle:   if (sync_in) next_state = st_data_i;
            st_data_i: if (sync_end) next_state = st_cnu;
            st_cnu:    if (cnu_done) next_state = st_vnu;
            // stop early on a clean syndrome or at the limit and loop otherwise
            st_vnu:    if (vnu_done) next_state = (parity_ok || iter_end) ? st_data_o : st_cnu;
            st_data_o: if (out_done) next_state = st_idle;
            default:   next_state = st_idle;
        endcase
    end

    // state and one-cycle start pulses on phase entry
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state <= st_idle;
            load_start <= 1'b0;
            cnu_start <= 1'b0;
            vnu_start <= 1'b0;
            out_start <= 1'b0;
            num_iter <= '0;
        end
        else
        begin
            state <= next_state;
            load_start <= (state == st_idle) && (next_state == st_data_i);
            cnu_start <= enter_cnu;
            vnu_start <= (next_state == st_vnu) && (state != st_vnu);
            out_start <= (next_state == st_data_o) && (state != st_data_o);
            // count kept until the next frame
            if (sync_in)
                num_iter <= '0;
            else if (enter_cnu)
                num_iter <= num_iter + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            sync_dly <= 1'b0;
            sync_dly2 <= 1'b0;
            busy <= 1'b0;
            finish <= 1'b0;
            decode_err <= 1'b0;
        end
        else
        begin
            sync_dly <= sync_in;
            sync_dly2 <= sync_dly;
            finish <= out_done;
            if (finish)
                busy <= 1'b0;
            else if (sync_end)
                busy <= 1'b1;
            // last syndrome verdict
            if (vnu_done)
                decode_err <= ~parity_ok;
        end
    end

    // zero limit would never end the loop
    a_max_iter_nz: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(sync_in) |-> max_iter != '0);

    // start pulses one-hot and never in the same cycle as a unit's done pulse
    a_pulse_onehot: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({cnu_start, vnu_start, load_start, out_start,
                  cnu_done, vnu_done, out_done}));

endmodule

// File: verilog/llr_io.sv
// channel LLR loader and hard decision streamer on the shared LLR ram
module llr_io #(
    parameter int llr_w = 6
) (
    input  logic clk,
    input  logic reset_n,
    input  logic sync_in,
    input  ldpc_pkg::llr_t llr_in,
    input  logic out_start,
    output logic dout,
    output logic dout_valid,
    output logic out_done,
    llr_mem_if.requester mem
);
    import ldpc_pkg::*;

    // init pass covers lq copy and r clear, ends on the last r word
    localparam addr_t init_last = addr_t'(2 * n_bits + n_edges - 1);
    localparam addr_t lq_base = addr_t'(n_bits);

    addr_t cnt;
    logic sync_q;
    logic init_act;
    logic out_act;
    logic granted;
    logic rd_pend;
    logic rd_last;

    assign granted = mem.req & mem.gnt;

    always_comb
    begin
        mem.req = 1'b0;
        mem.wr = 1'b0;
        mem.addr = cnt;
        mem.wdata = llr_w'(llr_in);
        if (sync_in)
        begin
            // lr word straight from the channel
            mem.req = 1'b1;
            mem.wr = 1'b1;
        end
        else if (init_act)
        begin
            mem.req = 1'b1;
            if (cnt < addr_t'(2 * n_bits))
            begin
                // even steps read lr, odd steps write it back as lq
                mem.wr = cnt[0];
                mem.addr = cnt[0] ? lq_base + (cnt >> 1) : cnt >> 1;
                mem.wdata = mem.rdata;
            end
            else
            begin
                // edge messages start at zero
                mem.wr = 1'b1;
                mem.wdata = '0;
            end
        end
        else if (out_act)
        begin
            mem.req = 1'b1;
            mem.addr = lq_base + cnt;
        end
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            cnt <= '0;
            sync_q <= 1'b0;
            init_act <= 1'b0;
            out_act <= 1'b0;
            rd_pend <= 1'b0;
            rd_last <= 1'b0;
            dout_valid <= 1'b0;
            out_done <= 1'b0;
        end
        else
        begin
            sync_q <= sync_in;
            // read in flight, its data shows one cycle later
            rd_pend <= out_act && granted;
            rd_last <= cnt == addr_t'(n_bits - 1);
            dout_valid <= rd_pend;
            out_done <= rd_pend && rd_last;
            if (sync_q && !sync_in)
            begin
                init_act <= 1'b1;
                cnt <= '0;
            end
            else if (out_start)
                out_act <= 1'b1;
            else if (granted)
            begin
                if (init_act && cnt == init_last)
                begin
                    init_act <= 1'b0;
                    cnt <= '0;
                end
                else if (out_act && cnt == addr_t'(n_bits - 1))
                begin
                    out_act <= 1'b0;
                    cnt <= '0;
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    // sign of the posterior is the decision
    always_ff @(posedge clk)
    begin
        if (rd_pend)
            dout <= mem.rdata[llr_w-1];
    end

endmodule

// File: verilog/cnu.sv
// check node unit, min-sum update of the edge messages one check at a time
module cnu #(
    parameter int llr_w = 6
) (
    input  logic clk,
    input  logic reset_n,
    input  logic cnu_start,
    output logic cnu_done,
    llr_mem_if.requester mem
);
    import ldpc_pkg::*;

    logic active;
    logic [2:0] chk;
    // 0..7 reads (lq, r per edge), 8 wait, 9..12 writes
    logic [3:0] step;
    logic granted;
    logic [1:0] wr_j;
    logic [4:0] edge_idx;
    logic rd_vld;
    logic [2:0] rd_step;
    logic signed [llr_w-1:0] q_buf;
    logic signed [llr_w:0] ext_full;
    logic signed [llr_w-1:0] ext;
    logic [llr_w-2:0] ext_mag;
    logic [llr_w-2:0] min1;
    logic [llr_w-2:0] min2;
    logic [1:0] min_pos;
    logic sgn_prod;
    logic [row_w-1:0] ext_sgn;
    logic [llr_w-2:0] out_mag;
    logic signed [llr_w-1:0] mag_s;

    assign granted = mem.req & mem.gnt;
    assign wr_j = 2'(step - 4'd9);
    assign edge_idx = {chk, step[3] ? wr_j : step[2:1]};

    assign mem.req = active && (step != 4'd8);
    assign mem.wr = step > 4'd8;
    assign mem.addr = (!step[3] && !step[0]) ? addr_t'(n_bits) + addr_t'(edge_bit[edge_idx])
                                             : addr_t'(2 * n_bits) + addr_t'(edge_idx);

    // extrinsic = posterior minus old message, clipped
    assign ext_full = q_buf - mem.rdata;
    always_comb
    begin
        if (ext_full > llr_max)
            ext = llr_w'(llr_max);
        else if (ext_full < -llr_max)
            ext = llr_w'(-llr_max);
        else
            ext = ext_full[llr_w-1:0];
        ext_mag = (llr_w-1)'(ext[llr_w-1] ? -ext : ext);
    end

    // min2 goes back to the minimum's own edge
    assign out_mag = (wr_j == min_pos) ? min2 : min1;
    assign mag_s = {1'b0, out_mag};
    assign mem.wdata = (sgn_prod ^ ext_sgn[wr_j]) ? -mag_s : mag_s;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            active <= 1'b0;
            chk <= '0;
            step <= '0;
            cnu_done <= 1'b0;
            rd_vld <= 1'b0;
        end
        else
        begin
            cnu_done <= 1'b0;
            rd_vld <= granted && !mem.wr;
            if (cnu_start)
            begin
                active <= 1'b1;
                chk <= '0;
                step <= '0;
            end
            else if (active && (granted || step == 4'd8))
            begin
                if (step == 4'd12)
                begin
                    step <= '0;
                    if (chk == 3'(n_checks - 1))
                    begin
                        active <= 1'b0;
                        cnu_done <= 1'b1;
                    end
                    else
                        chk <= chk + 1'b1;
                end
                else
                    step <= step + 1'b1;
            end
        end
    end

    // running min, second min and sign product over the row
    always_ff @(posedge clk)
    begin
        rd_step <= step[2:0];
        if (rd_vld && !rd_step[0])
            q_buf <= mem.rdata;
        if (rd_vld && rd_step[0])
        begin
            ext_sgn[rd_step[2:1]] <= ext[llr_w-1];
            if (rd_step[2:1] == 2'd0)
            begin
                min1 <= ext_mag;
                min2 <= (llr_w-1)'(llr_max);
                min_pos <= 2'd0;
                sgn_prod <= ext[llr_w-1];
            end
            else
            begin
                sgn_prod <= sgn_prod ^ ext[llr_w-1];
                if (ext_mag < min1)
                begin
                    min2 <= min1;
                    min1 <= ext_mag;
                    min_pos <= rd_step[2:1];
                end
                else if (ext_mag < min2)
                    min2 <= ext_mag;
            end
        end
    end

endmodule

// File: verilog/vnu.sv
// variable node unit: posterior sums, hard decisions and syndrome
module vnu #(
    parameter int llr_w = 6
) (
    input  logic clk,
    input  logic reset_n,
    input  logic vnu_start,
    output logic vnu_done,
    output logic parity_ok,
    llr_mem_if.requester mem
);
    import ldpc_pkg::*;

    logic active;
    logic [3:0] bit_idx;
    // 0 lr, 1..2 edge messages, 3 wait for the sum, 4 write lq
    logic [2:0] step;
    logic granted;
    logic rd_vld;
    logic [1:0] rd_step;
    logic signed [llr_w+1:0] acc;
    logic signed [llr_w-1:0] post;
    logic [n_checks-1:0] syndrome;

    assign granted = mem.req & mem.gnt;
    assign parity_ok = ~|syndrome;

    assign mem.req = active && (step != 3'd3);
    assign mem.wr = step == 3'd4;
    assign mem.wdata = post;

    always_comb
    begin
        case (step)
            3'd0:    mem.addr = addr_t'(bit_idx);
            3'd1:    mem.addr = addr_t'(2 * n_bits) + addr_t'(bit_edges[bit_idx][0]);
            3'd2:    mem.addr = addr_t'(2 * n_bits) + addr_t'(bit_edges[bit_idx][1]);
            default: mem.addr = addr_t'(n_bits) + addr_t'(bit_idx);
        endcase
        // clip the three-term sum
        if (acc > llr_max)
            post = llr_w'(llr_max);
        else if (acc < -llr_max)
            post = llr_w'(-llr_max);
        else
            post = acc[llr_w-1:0];
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            active <= 1'b0;
            bit_idx <= '0;
            step <= '0;
            vnu_done <= 1'b0;
            rd_vld <= 1'b0;
            syndrome <= '0;
        end
        else
        begin
            vnu_done <= 1'b0;
            rd_vld <= granted && !mem.wr;
            if (vnu_start)
            begin
                active <= 1'b1;
                bit_idx <= '0;
                step <= '0;
                syndrome <= '0;
            end
            else if (active && (granted || step == 3'd3))
            begin
                if (step == 3'd4)
                begin
                    // decision flips both checks of this bit
                    syndrome[bit_edges[bit_idx][0][4:2]] <=
                        syndrome[bit_edges[bit_idx][0][4:2]] ^ post[llr_w-1];
                    syndrome[bit_edges[bit_idx][1][4:2]] <=
                        syndrome[bit_edges[bit_idx][1][4:2]] ^ post[llr_w-1];
                    step <= '0;
                    if (bit_idx == 4'(n_bits - 1))
                    begin
                        active <= 1'b0;
                        vnu_done <= 1'b1;
                    end
                    else
                        bit_idx <= bit_idx + 1'b1;
                end
                else
                    step <= step + 1'b1;
            end
        end
    end

    // lr starts the sum, edge messages add on
    always_ff @(posedge clk)
    begin
        rd_step <= step[1:0];
        if (rd_vld)
        begin
            if (rd_step == 2'd0)
                acc <= mem.rdata;
            else
                acc <= acc + mem.rdata;
        end
    end

endmodule

// File: verilog/llr_ram_arbiter.sv
// shared 48-word LLR ram behind a fixed-priority arbiter for io, vnu and cnu
module llr_ram_arbiter #(
    parameter int llr_w = 6
) (
    input  logic clk,
    input  logic reset_n,
    llr_mem_if.arbiter io_port,
    llr_mem_if.arbiter vnu_port,
    llr_mem_if.arbiter cnu_port
);
    import ldpc_pkg::*;

    localparam int n_words = 2 * n_bits + n_edges;

    logic signed [llr_w-1:0] ram [n_words];
    req_e win;
    logic any_req;
    logic wr;
    addr_t addr;
    logic signed [llr_w-1:0] wdata;

    // io over vnu over cnu
    assign io_port.gnt = io_port.req;
    assign vnu_port.gnt = vnu_port.req & ~io_port.req;
    assign cnu_port.gnt = cnu_port.req & ~io_port.req & ~vnu_port.req;
    assign any_req = io_port.req | vnu_port.req | cnu_port.req;

    always_comb
    begin
        win = req_cnu;
        wr = cnu_port.wr;
        addr = cnu_port.addr;
        wdata = cnu_port.wdata;
        if (io_port.req)
        begin
            win = req_io;
            wr = io_port.wr;
            addr = io_port.addr;
            wdata = io_port.wdata;
        end
        else if (vnu_port.req)
        begin
            win = req_vnu;
            wr = vnu_port.wr;
            addr = vnu_port.addr;
            wdata = vnu_port.wdata;
        end
    end

    // each port keeps its last read word until it reads again
    always_ff @(posedge clk)
    begin
        if (any_req && wr)
            ram[addr] <= wdata;
        if (any_req && !wr)
        begin
            case (win)
                req_io:  io_port.rdata <= ram[addr];
                req_vnu: vnu_port.rdata <= ram[addr];
                default: cnu_port.rdata <= ram[addr];
            endcase
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (!reset_n)
        any_req |-> addr < addr_t'(n_words))
        else $error("llr ram %s address %0d out of range", win.name(), addr);

endmodule

// File: verilog/ldpc_top.sv
// min-sum LDPC decoder: controller, check and variable units, io and shared LLR ram
module ldpc_top #(
    parameter int llr_w = 6
) (
    input  logic clk,
    input  logic reset_n,
    input  logic sync_in,
    input  ldpc_pkg::llr_t llr_in,
    input  logic [ldpc_pkg::max_iter_w-1:0] max_iter,
    output logic dout,
    output logic dout_valid,
    output logic busy,
    output logic finish,
    output logic [ldpc_pkg::max_iter_w-1:0] num_iter,
    output logic decode_err
);

    logic cnu_start;
    logic vnu_start;
    logic out_start;
    logic cnu_done;
    logic vnu_done;
    logic out_done;
    logic parity_ok;

    llr_mem_if #(.llr_w(llr_w)) io_bus ();
    llr_mem_if #(.llr_w(llr_w)) vnu_bus ();
    llr_mem_if #(.llr_w(llr_w)) cnu_bus ();

    // io follows sync_in itself, load timing is fixed
    ldpc_ctrl u_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .sync_in    (sync_in),
        .max_iter   (max_iter),
        .cnu_done   (cnu_done),
        .vnu_done   (vnu_done),
        .parity_ok  (parity_ok),
        .out_done   (out_done),
        .cnu_start  (cnu_start),
        .vnu_start  (vnu_start),
        .load_start (),
        .out_start  (out_start),
        .busy       (busy),
        .finish     (finish),
        .num_iter   (num_iter),
        .decode_err (decode_err)
    );

    llr_io #(.llr_w(llr_w)) u_io (
        .clk        (clk),
        .reset_n    (reset_n),
        .sync_in    (sync_in),
        .llr_in     (llr_in),
        .out_start  (out_start),
        .dout       (dout),
        .dout_valid (dout_valid),
        .out_done   (out_done),
        .mem        (io_bus.requester)
    );

    cnu #(.llr_w(llr_w)) u_cnu (
        .clk       (clk),
        .reset_n   (reset_n),
        .cnu_start (cnu_start),
        .cnu_done  (cnu_done),
        .mem       (cnu_bus.requester)
    );

    vnu #(.llr_w(llr_w)) u_vnu (
        .clk       (clk),
        .reset_n   (reset_n),
        .vnu_start (vnu_start),
        .vnu_done  (vnu_done),
        .parity_ok (parity_ok),
        .mem       (vnu_bus.requester)
    );

    llr_ram_arbiter #(.llr_w(llr_w)) u_ram (
        .clk      (clk),
        .reset_n  (reset_n),
        .io_port  (io_bus.arbiter),
        .vnu_port (vnu_bus.arbiter),
        .cnu_port (cnu_bus.arbiter)
    );

endmodule

// File: sim/ldpc_tb.sv
// directed testbench for the min-sum LDPC decoder with framing, decode and syndrome checks
module ldpc_tb;
    import ldpc_pkg::*;

    localparam int clk_period = 100;
    localparam int reset_cycles = 16;
    // worst frame is eight full iterations plus load and output
    localparam int frame_cycles = 8 * 200 + 40;
    // clean 1, weak error 3, random 4 at limit 8, random 3 at limit 1
    localparam int n_frames = 11;

    logic clk = 1'b0;
    logic reset_n;
    logic sync_in;
    llr_t llr_in;
    logic [max_iter_w-1:0] max_iter;
    logic dout;
    logic dout_valid;
    logic busy;
    logic finish;
    logic [max_iter_w-1:0] num_iter;
    logic decode_err;

    integer seed;
    llr_t frame_llr [n_bits];
    logic [n_bits-1:0] got_bits;
    logic [max_iter_w-1:0] got_iter;
    logic got_err;

    ldpc_top #(.llr_w(6)) dut0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .sync_in    (sync_in),
        .llr_in     (llr_in),
        .max_iter   (max_iter),
        .dout       (dout),
        .dout_valid (dout_valid),
        .busy       (busy),
        .finish     (finish),
        .num_iter   (num_iter),
        .decode_err (decode_err)
    );

    initial
    begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog over every frame at the full iteration count
    initial
    begin
        #((n_frames * frame_cycles + 4 * reset_cycles) * clk_period);
        abort_run("watchdog expired, the decoder stopped responding");
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bits(input string name, input logic [n_bits-1:0] got,
                              input logic [n_bits-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_iter(input string name, input logic [max_iter_w-1:0] got,
                              input logic [max_iter_w-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    // parity of each check over its four edges
    function automatic logic [n_checks-1:0] syndrome_of(input logic [n_bits-1:0] bits);
        logic [n_checks-1:0] syn;
        int e;
        syn = '0;
        for (e = 0; e < n_edges; e++)
            syn[e / row_w] = syn[e / row_w] ^ bits[edge_bit[e]];
        return syn;
    endfunction

    // both tables must describe the same edges
    task automatic compare_edge_tables();
        int b;
        int k;
        for (b = 0; b < n_bits; b++)
            for (k = 0; k < col_w; k++)
                if (edge_bit[bit_edges[b][k]] != b)
                    abort_run($sformatf("edge tables disagree at bit %0d", b));
    endtask

    // one frame in with decisions and status collected at finish
    task automatic run_frame(input logic [max_iter_w-1:0] limit);
        int i;
        int n_valid;
        int wait_cycles;
        logic last_valid;
        logic done;
        n_valid = 0;
        wait_cycles = 0;
        last_valid = 1'b0;
        done = 1'b0;
        got_bits = '0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        max_iter = limit;
        for (i = 0; i < n_bits; i++)
        begin
            sync_in = 1'b1;
            llr_in = frame_llr[i];
            @(negedge clk);
        end
        sync_in = 1'b0;
        llr_in = '0;
        while (!done)
        begin
            if (wait_cycles > frame_cycles)
                abort_run("no finish pulse within the frame time limit");
            if (dout_valid)
            begin
                check_flag("busy", busy, 1'b1);
                if (n_valid > 0 && !last_valid)
                    abort_run("dout_valid pulses are not consecutive");
                if (n_valid >= n_bits)
                    abort_run("more than 12 dout_valid pulses in one frame");
                got_bits[n_valid] = dout;
                n_valid++;
            end
            if (finish)
            begin
                if (!last_valid || dout_valid)
                    abort_run("finish does not follow the last dout_valid");
                got_iter = num_iter;
                got_err = decode_err;
                done = 1'b1;
            end
            last_valid = dout_valid;
            wait_cycles++;
            @(negedge clk);
        end
        if (n_valid != n_bits)
            abort_run($sformatf("frame gave %0d dout_valid pulses instead of 12", n_valid));
        // single finish pulse and busy low right after
        check_flag("finish", finish, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("dout_valid", dout_valid, 1'b0);
        check_iter("num_iter", num_iter, got_iter);
        check_flag("decode_err", decode_err, got_err);
    endtask

    task automatic idle_after_reset();
        check_flag("busy", busy, 1'b0);
        check_flag("finish", finish, 1'b0);
        check_flag("dout_valid", dout_valid, 1'b0);
    endtask

    // strong all-zero codeword
    task automatic decode_clean_codeword();
        int i;
        for (i = 0; i < n_bits; i++)
            frame_llr[i] = llr_t'(20);
        run_frame(5'd8);
        check_bits("dout", got_bits, '0);
        check_iter("num_iter", got_iter, 5'd1);
        check_flag("decode_err", got_err, 1'b0);
    endtask

    // weak bit gets +20 from both checks and flips back in one pass
    task automatic repair_weak_bit(input int weak_bit);
        int i;
        for (i = 0; i < n_bits; i++)
            frame_llr[i] = llr_t'(20);
        frame_llr[weak_bit] = llr_t'(-3);
        run_frame(5'd8);
        check_bits("dout", got_bits, '0);
        check_iter("num_iter", got_iter, 5'd1);
        check_flag("decode_err", got_err, 1'b0);
    endtask

    task automatic decode_random_frames(input int n, input logic [max_iter_w-1:0] limit);
        int f;
        int i;
        logic [n_checks-1:0] syn;
        for (f = 0; f < n; f++)
        begin
            // values in -31..31
            for (i = 0; i < n_bits; i++)
                frame_llr[i] = llr_t'($random(seed) % (llr_max + 1));
            run_frame(limit);
            syn = syndrome_of(got_bits);
            if (got_iter < 1 || got_iter > limit)
                abort_run($sformatf("Error: num_iter got %h outside 01 to %h",
                                    got_iter, limit));
            // error flag must agree with the parity of the output
            check_flag("decode_err", got_err, |syn);
            if (got_err)
                check_iter("num_iter", got_iter, limit);
        end
    endtask

    initial
    begin
        seed = 32'h53efeaca;
        reset_n = 1'b0;
        sync_in = 1'b0;
        llr_in = '0;
        max_iter = 5'd8;
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b1;
        compare_edge_tables();
        idle_after_reset();
        decode_clean_codeword();
        repair_weak_bit(0);
        repair_weak_bit(5);
        repair_weak_bit(11);
        decode_random_frames(4, 5'd8);
        decode_random_frames(3, 5'd1);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: sim.f
verilog/ldpc_pkg.sv
verilog/llr_mem_if.sv
verilog/ldpc_ctrl.sv
verilog/llr_io.sv
verilog/cnu.sv
verilog/vnu.sv
verilog/llr_ram_arbiter.sv
verilog/ldpc_top.sv
sim/ldpc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LDPC decoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module ldpc_tb -f sim.f -o ldpc_sim
./obj_dir/ldpc_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
